// ==== cam_bist_config.svh ====
/*
 * CAM geometry for the BIST subsystem
 * Entry width, entry count and entry address width
 */

`ifndef CAM_BIST_CONFIG_SVH
`define CAM_BIST_CONFIG_SVH

// Bits per CAM entry
`define CAM_WIDTH 16

// Number of CAM entries
`define CAM_ENTRIES 16

// Entry address width, log2 of CAM_ENTRIES
`define CAM_ADDR_W 4

`endif

// ==== cam_types_pkg.sv ====
/*
 * CAM datapath types
 * Entry data, entry address and match vector
 */

`include "cam_bist_config.svh"

package cam_types_pkg;

   // Write data, compare key and compare mask
   typedef logic [`CAM_WIDTH-1:0] cam_data_t;

   // Entry index
   typedef logic [`CAM_ADDR_W-1:0] cam_addr_t;

   // One hit bit per entry, bit i for entry i
   typedef logic [`CAM_ENTRIES-1:0] cam_match_t;

endpackage

// ==== bist_pkg.sv ====
/*
 * BIST control types
 * Sequencer state encoding and fail counter width
 */

package bist_pkg;

   // Sequencer states
   // WRITE       solid background into every entry
   // CMP_MASKED  key has one bit flipped, all entries should miss
   // CMP_OPEN    key equals background, all entries should hit
   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      WRITE      = 3'd1,
      CMP_MASKED = 3'd2,
      CMP_OPEN   = 3'd3,
      DONE       = 3'd4
   } bist_state_e;

   // Failing compare count, saturates at all ones
   typedef logic [15:0] fail_cnt_t;

endpackage

// ==== bist_sequencer.sv ====
/*
 * BIST sequencer for the CAM
 * Two polarity passes of background write plus masked/open compares
 * Mission write and search forwarding when no BIST run is active
 */

`timescale 1ns/1ps

`include "cam_bist_config.svh"

module bist_sequencer (
   input  logic                     bist_clk,
   input  logic                     rst_b,
   input  logic                     bist_start,
   input  logic                     func_wr_en,
   input  cam_types_pkg::cam_addr_t func_wr_addr,
   input  cam_types_pkg::cam_data_t func_wr_data,
   input  logic                     func_search_en,
   output logic                     bist_busy,
   output logic                     bist_done,
   output logic                     bist_mode,
   output logic                     rotate_mask,
   output logic                     mask_en,
   output logic                     data_inv,
   output cam_types_pkg::cam_data_t raw_wr_data,
   output logic                     wr_en,
   output cam_types_pkg::cam_addr_t wr_addr,
   output logic                     search_en,
   output logic                     check_en,
   output logic                     expect_hit
);

   localparam int BIT_W = $clog2(`CAM_WIDTH);

   localparam cam_types_pkg::cam_addr_t LAST_ADDR = cam_types_pkg::cam_addr_t'(`CAM_ENTRIES - 1);
   localparam logic [BIT_W-1:0]         LAST_BIT  = BIT_W'(`CAM_WIDTH - 1);

   bist_pkg::bist_state_e    state_q;
   cam_types_pkg::cam_addr_t addr_q;
   logic [BIT_W-1:0]         bit_q;
   // Polarity of the current pass, 1 means inverted background
   logic                     pol_q;

   //------------------------------------------------------------
   // State and pass counters
   //------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state_q <= bist_pkg::IDLE;
         addr_q  <= '0;
         bit_q   <= '0;
         pol_q   <= 1'b0;
      end else begin
         case (state_q)
            bist_pkg::IDLE, bist_pkg::DONE: begin
               // Start only from rest, a run always begins with polarity 0
               if (bist_start) begin
                  state_q <= bist_pkg::WRITE;
                  addr_q  <= '0;
                  bit_q   <= '0;
                  pol_q   <= 1'b0;
               end
            end
            bist_pkg::WRITE: begin
               addr_q <= addr_q + 1'b1;
               if (addr_q == LAST_ADDR) begin
                  state_q <= bist_pkg::CMP_MASKED;
                  bit_q   <= '0;
               end
            end
            bist_pkg::CMP_MASKED: begin
               state_q <= bist_pkg::CMP_OPEN;
            end
            bist_pkg::CMP_OPEN: begin
               bit_q <= bit_q + 1'b1;
               if (bit_q != LAST_BIT) begin
                  state_q <= bist_pkg::CMP_MASKED;
               end else if (pol_q) begin
                  state_q <= bist_pkg::DONE;
               end else begin
                  // Second pass with inverted background
                  state_q <= bist_pkg::WRITE;
                  addr_q  <= '0;
                  pol_q   <= 1'b1;
               end
            end
            default: state_q <= bist_pkg::IDLE;
         endcase
      end
   end

   //------------------------------------------------------------
   // Operation decode
   //------------------------------------------------------------
   always_comb begin
      bist_busy   = 1'b0;
      bist_done   = 1'b0;
      rotate_mask = 1'b0;
      mask_en     = 1'b0;
      wr_en       = 1'b0;
      search_en   = 1'b0;
      check_en    = 1'b0;
      expect_hit  = 1'b0;
      wr_addr     = func_wr_addr;
      raw_wr_data = func_wr_data;
      case (state_q)
         bist_pkg::WRITE: begin
            bist_busy   = 1'b1;
            wr_en       = 1'b1;
            wr_addr     = addr_q;
            // Zero background, polarity applied in the input handler
            raw_wr_data = '0;
         end
         bist_pkg::CMP_MASKED: begin
            bist_busy   = 1'b1;
            search_en   = 1'b1;
            mask_en     = 1'b1;
            // Mask steps to the next bit after this compare
            rotate_mask = 1'b1;
            check_en    = 1'b1;
            raw_wr_data = '0;
         end
         bist_pkg::CMP_OPEN: begin
            bist_busy   = 1'b1;
            search_en   = 1'b1;
            check_en    = 1'b1;
            expect_hit  = 1'b1;
            raw_wr_data = '0;
         end
         default: begin
            // IDLE or DONE, mission requests pass through
            bist_done = (state_q == bist_pkg::DONE);
            wr_en     = func_wr_en;
            search_en = func_search_en;
         end
      endcase
   end

   assign bist_mode = bist_busy;
   assign data_inv  = bist_busy & pol_q;

   // One operation per cycle, a mission caller never writes and searches together
   a_no_wr_search: assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      !(wr_en && search_en)
   );

endmodule

// ==== cam_bist_inhandler.sv ====
/*
 * CAM BIST input handler
 * Write data polarity, rotating one-hot compare mask, compare key select
 */

`timescale 1ns/1ps

`include "cam_bist_config.svh"

module cam_bist_inhandler (
   input  logic                     bist_clk,
   input  logic                     rst_b,
   input  logic                     bist_mode,
   input  logic                     rotate_mask,
   input  logic                     mask_en,
   input  logic                     data_inv,
   input  cam_types_pkg::cam_data_t raw_wr_data,
   input  cam_types_pkg::cam_data_t func_key,
   output cam_types_pkg::cam_data_t wr_data,
   output cam_types_pkg::cam_data_t cm_key
);

   // One-hot mask, selects the key bit flipped in a masked compare
   cam_types_pkg::cam_data_t bist_mask;
   cam_types_pkg::cam_data_t cmp_data;

   //------------------------------------------------------------
   // Rotating mask
   //------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_mask <= cam_types_pkg::cam_data_t'(1);
      end else if (rotate_mask) begin
         // Rotate left, top bit wraps to bit 0
         bist_mask <= {bist_mask[`CAM_WIDTH-2:0], bist_mask[`CAM_WIDTH-1]};
      end
   end

   //------------------------------------------------------------
   // Write data and compare key
   //------------------------------------------------------------
   // Polarity applied to every bit of the write data
   assign wr_data = raw_wr_data ^ {`CAM_WIDTH{data_inv}};

   // Key follows the stored background, one bit flipped when masked
   assign cmp_data = wr_data ^ (bist_mask & {`CAM_WIDTH{mask_en}});

   // Mission key outside a BIST run
   assign cm_key = bist_mode ? cmp_data : func_key;

   // One-hot during a run, and back at bit 0 whenever no run is active
   a_mask_onehot: assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      bist_mode ? $onehot(bist_mask) : (bist_mask == cam_types_pkg::cam_data_t'(1))
   );

endmodule

// ==== cam_array.sv ====
/*
 * CAM storage array
 * Entry registers with one write port
 * Parallel search of all entries with a registered match vector
 */

`timescale 1ns/1ps

`include "cam_bist_config.svh"

module cam_array (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      wr_en,
   input  cam_types_pkg::cam_addr_t  wr_addr,
   input  cam_types_pkg::cam_data_t  wr_data,
   input  logic                      search_en,
   input  cam_types_pkg::cam_data_t  cm_key,
   output cam_types_pkg::cam_match_t match,
   output logic                      match_valid
);

   // Entry storage
   cam_types_pkg::cam_data_t  entry_q [`CAM_ENTRIES];
   // Unregistered hit vector for the current key
   cam_types_pkg::cam_match_t hit;

   //------------------------------------------------------------
   // Write port
   //------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         for (int e = 0; e < `CAM_ENTRIES; e++) begin
            entry_q[e] <= '0;
         end
      end else if (wr_en) begin
         // New data seen by searches from the next cycle
         entry_q[wr_addr] <= wr_data;
      end
   end

   //------------------------------------------------------------
   // Parallel compare
   //------------------------------------------------------------
   always_comb begin
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         // Full-width equality, no per-bit don't care
         hit[e] = (entry_q[e] == cm_key);
      end
   end

   // Match result held until the next search
   always_ff @(posedge bist_clk) begin
      if (search_en) begin
         match <= hit;
      end
   end

   // One-cycle valid pulse per search
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= search_en;
      end
   end

endmodule

// ==== match_analyzer.sv ====
/*
 * BIST match analyzer
 * Expected result alignment, match check, fail flag, saturating fail counter
 */

`timescale 1ns/1ps

module match_analyzer (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      bist_start,
   input  logic                      check_en,
   input  logic                      expect_hit,
   input  cam_types_pkg::cam_match_t match,
   input  logic                      match_valid,
   output logic                      bist_fail,
   output bist_pkg::fail_cnt_t       fail_count
);

   // Compare controls delayed to line up with the array output
   logic                      chk_q;
   logic                      exp_q;
   cam_types_pkg::cam_match_t expected;
   logic                      result_fail;

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         chk_q <= 1'b0;
         exp_q <= 1'b0;
      end else begin
         chk_q <= check_en;
         exp_q <= expect_hit;
      end
   end

   //------------------------------------------------------------
   // Result check
   //------------------------------------------------------------
   always_comb begin
      // All entries hit on an open compare, none on a masked one
      if (exp_q) begin
         expected = '1;
      end else begin
         expected = '0;
      end
   end

   assign result_fail = chk_q & match_valid & (match != expected);

   // One count per failing compare, not per failing entry
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_fail  <= 1'b0;
         fail_count <= '0;
      end else if (bist_start) begin
         bist_fail  <= 1'b0;
         fail_count <= '0;
      end else if (result_fail) begin
         bist_fail <= 1'b1;
         // Hold at max
         if (fail_count != '1) begin
            fail_count <= fail_count + 1'b1;
         end
      end
   end

   // Every BIST compare yields a match result one cycle later
   a_chk_valid: assert property (
      @(posedge bist_clk) disable iff (!rst_b)
      chk_q |-> match_valid
   );

endmodule

// ==== cam_bist_top.sv ====
/*
 * CAM with BIST, top level
 * Sequencer, input handler, CAM array and match analyzer
 */

`timescale 1ns/1ps

module cam_bist_top (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      bist_start,
   output logic                      bist_busy,
   output logic                      bist_done,
   output logic                      bist_fail,
   output bist_pkg::fail_cnt_t       fail_count,
   input  logic                      func_wr_en,
   input  cam_types_pkg::cam_addr_t  func_wr_addr,
   input  cam_types_pkg::cam_data_t  func_wr_data,
   input  logic                      func_search_en,
   input  cam_types_pkg::cam_data_t  func_key,
   output cam_types_pkg::cam_match_t match,
   output logic                      match_valid
);

   // Sequencer to input handler
   logic                     bist_mode;
   logic                     rotate_mask;
   logic                     mask_en;
   logic                     data_inv;
   cam_types_pkg::cam_data_t raw_wr_data;

   // Sequencer to array
   logic                     wr_en;
   cam_types_pkg::cam_addr_t wr_addr;
   logic                     search_en;

   // Input handler to array
   cam_types_pkg::cam_data_t wr_data;
   cam_types_pkg::cam_data_t cm_key;

   // Sequencer to analyzer
   logic                     check_en;
   logic                     expect_hit;

   bist_sequencer u_seq (
      .bist_clk       (bist_clk),
      .rst_b          (rst_b),
      .bist_start     (bist_start),
      .func_wr_en     (func_wr_en),
      .func_wr_addr   (func_wr_addr),
      .func_wr_data   (func_wr_data),
      .func_search_en (func_search_en),
      .bist_busy      (bist_busy),
      .bist_done      (bist_done),
      .bist_mode      (bist_mode),
      .rotate_mask    (rotate_mask),
      .mask_en        (mask_en),
      .data_inv       (data_inv),
      .raw_wr_data    (raw_wr_data),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .search_en      (search_en),
      .check_en       (check_en),
      .expect_hit     (expect_hit)
   );

   cam_bist_inhandler u_inh (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_mode   (bist_mode),
      .rotate_mask (rotate_mask),
      .mask_en     (mask_en),
      .data_inv    (data_inv),
      .raw_wr_data (raw_wr_data),
      .func_key    (func_key),
      .wr_data     (wr_data),
      .cm_key      (cm_key)
   );

   cam_array u_cam (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .search_en   (search_en),
      .cm_key      (cm_key),
      .match       (match),
      .match_valid (match_valid)
   );

   match_analyzer u_ana (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_start  (bist_start),
      .check_en    (check_en),
      .expect_hit  (expect_hit),
      .match       (match),
      .match_valid (match_valid),
      .bist_fail   (bist_fail),
      .fail_count  (fail_count)
   );

endmodule

// ==== tb_cam_bist.sv ====
/*
 * Testbench for the CAM BIST subsystem
 * Clock, reset, LFSR stimulus, reference model, match checker and watchdog
 * Stuck-at-1 injection by force on a single storage bit
 */

`timescale 1ns/1ps

`include "cam_bist_config.svh"

module tb_cam_bist;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   // Operation cycles of one BIST run and the wait bound taken from it
   localparam int BIST_OPS     = 2 * (`CAM_ENTRIES + 2 * `CAM_WIDTH);
   localparam int BIST_BOUND   = 2 * BIST_OPS + 20;
   localparam int N_SEARCH     = 16;
   localparam int MISSION_CYCLES  = `CAM_ENTRIES + N_SEARCH + 8;
   // Four BIST runs, the mission test and some slack
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * (BIST_BOUND + 4) + MISSION_CYCLES + 40;

   logic                      bist_clk;
   logic                      rst_b;
   logic                      bist_start;
   logic                      bist_busy;
   logic                      bist_done;
   logic                      bist_fail;
   bist_pkg::fail_cnt_t       fail_count;
   logic                      func_wr_en;
   cam_types_pkg::cam_addr_t  func_wr_addr;
   cam_types_pkg::cam_data_t  func_wr_data;
   logic                      func_search_en;
   cam_types_pkg::cam_data_t  func_key;
   cam_types_pkg::cam_match_t match;
   logic                      match_valid;

   // Reference copy of the array contents in mission mode
   cam_types_pkg::cam_data_t  model_mem [`CAM_ENTRIES];
   // Expected match vectors, one per issued search
   cam_types_pkg::cam_match_t expect_q [$];
   cam_types_pkg::cam_match_t checked_match;
   logic [31:0]               lfsr_q = 32'h06d00f12;
   int                        errors;
   int                        tests_failed;
   int                        fault_entry;
   int                        fault_bit;
   logic                      fault_on;

   cam_bist_top dut0 (
      .bist_clk       (bist_clk),
      .rst_b          (rst_b),
      .bist_start     (bist_start),
      .bist_busy      (bist_busy),
      .bist_done      (bist_done),
      .bist_fail      (bist_fail),
      .fail_count     (fail_count),
      .func_wr_en     (func_wr_en),
      .func_wr_addr   (func_wr_addr),
      .func_wr_data   (func_wr_data),
      .func_search_en (func_search_en),
      .func_key       (func_key),
      .match          (match),
      .match_valid    (match_valid)
   );

   initial begin
      bist_clk = 1'b0;
   end

   always #(CLK_PERIOD / 2) bist_clk = ~bist_clk;

   //------------------------------------------------------------
   // Fault injection
   //------------------------------------------------------------
   // One forcing block per storage bit, only the selected one acts
   for (genvar ge = 0; ge < `CAM_ENTRIES; ge++) begin : g_fault_entry
      for (genvar gb = 0; gb < `CAM_WIDTH; gb++) begin : g_fault_bit
         always @(fault_on) begin
            if (fault_entry == ge && fault_bit == gb) begin
               if (fault_on) begin
                  force dut0.u_cam.entry_q[ge][gb] = 1'b1;
               end else begin
                  release dut0.u_cam.entry_q[ge][gb];
               end
            end
         end
      end
   end

   //------------------------------------------------------------
   // Stimulus source and reference model
   //------------------------------------------------------------
   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        out_bit;
      val = '0;
      for (int i = 0; i < n; i++) begin
         out_bit = lfsr_q[0];
         lfsr_q  = lfsr_q >> 1;
         if (out_bit) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
         end
         val = {val[30:0], out_bit};
      end
      return val;
   endfunction

   // Hit vector of the mission model for one key
   function automatic cam_types_pkg::cam_match_t ref_mission_hits(
      input cam_types_pkg::cam_data_t key);
      cam_types_pkg::cam_match_t hits;
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         hits[e] = (model_mem[e] == key);
      end
      return hits;
   endfunction

   // Failing compares of a full run, optionally with one bit stuck at 1
   function automatic int ref_fail_count(input logic fault, input int f_entry,
                                         input int f_bit);
      cam_types_pkg::cam_data_t  bg;
      cam_types_pkg::cam_data_t  stored;
      cam_types_pkg::cam_match_t masked_hits;
      cam_types_pkg::cam_match_t open_hits;
      int                        fails;
      fails = 0;
      for (int pol = 0; pol < 2; pol++) begin
         bg = '0;
         if (pol == 1) begin
            bg = '1;
         end
         for (int k = 0; k < `CAM_WIDTH; k++) begin
            for (int e = 0; e < `CAM_ENTRIES; e++) begin
               stored = bg;
               if (fault && e == f_entry) begin
                  stored[f_bit] = 1'b1;
               end
               masked_hits[e] = (stored == (bg ^ (cam_types_pkg::cam_data_t'(1) << k)));
               open_hits[e]   = (stored == bg);
            end
            // Masked key should miss everywhere, open key hit everywhere
            if (masked_hits != '0) begin
               fails++;
            end
            if (open_hits != '1) begin
               fails++;
            end
         end
      end
      return fails;
   endfunction

   //------------------------------------------------------------
   // Match checker
   //------------------------------------------------------------
   // BIST searches push nothing, so only mission results are compared
   always @(negedge bist_clk) begin
      if (rst_b && match_valid && expect_q.size() > 0) begin
         checked_match = expect_q.pop_front();
         if (match !== checked_match) begin
            $display("CHECK FAILED at %0t ns: match is %h, expected %h",
                     $time, match, checked_match);
            errors++;
         end
      end
   end

   // All tasks start and end on a falling edge
   task automatic run_bist(input logic disturb, output logic finished);
      int cyc;
      bist_start = 1'b1;
      @(negedge bist_clk);
      bist_start = 1'b0;
      cyc = 1;
      while (!bist_done && cyc < BIST_BOUND) begin
         if (bist_busy !== 1'b1) begin
            $display("CHECK FAILED at %0t ns: bist_busy is %b during a BIST run",
                     $time, bist_busy);
            errors++;
         end
         // Late mission writes land after the last background write
         func_wr_en = disturb && cyc > BIST_OPS - 30;
         func_wr_addr = cam_types_pkg::cam_addr_t'(rand_bits(`CAM_ADDR_W));
         func_wr_data = cam_types_pkg::cam_data_t'({rand_bits(`CAM_WIDTH - 1), 1'b0});
         @(negedge bist_clk);
         cyc++;
      end
      func_wr_en = 1'b0;
      finished   = bist_done;
      // Last compare result still has to reach the fail counter
      repeat (2) @(negedge bist_clk);
   endtask

   task automatic check_bist_result(input logic finished, input int exp_count);
      if (!finished) begin
         $display("bist_done did not rise within %0d cycles of bist_start", BIST_BOUND);
         errors++;
      end
      if (fail_count !== bist_pkg::fail_cnt_t'(exp_count)) begin
         $display("CHECK FAILED at %0t ns: fail_count is %0d, expected %0d",
                  $time, fail_count, exp_count);
         errors++;
      end
      if (bist_fail !== (exp_count != 0)) begin
         $display("CHECK FAILED at %0t ns: bist_fail is %b, expected %b",
                  $time, bist_fail, exp_count != 0);
         errors++;
      end
   endtask

   task automatic search_and_drain(input cam_types_pkg::cam_data_t key);
      func_search_en = 1'b1;
      func_key       = key;
      expect_q.push_back(ref_mission_hits(key));
      @(negedge bist_clk);
      func_search_en = 1'b0;
   endtask

   task automatic mission_test();
      int src;
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         func_wr_en   = 1'b1;
         func_wr_addr = cam_types_pkg::cam_addr_t'(e);
         func_wr_data = cam_types_pkg::cam_data_t'(rand_bits(`CAM_WIDTH));
         model_mem[e] = func_wr_data;
         @(negedge bist_clk);
      end
      func_wr_en = 1'b0;
      // Alternate keys copied from entries with fresh random keys
      for (int s = 0; s < N_SEARCH; s++) begin
         if (s % 2 == 0) begin
            src = rand_bits(`CAM_ADDR_W);
            search_and_drain(model_mem[src]);
         end else begin
            search_and_drain(cam_types_pkg::cam_data_t'(rand_bits(`CAM_WIDTH)));
         end
      end
      repeat (2) @(negedge bist_clk);
   endtask

   task automatic finish_test(input int num, input string name, input int err_start);
      if (expect_q.size() != 0) begin
         $display("%0d expected match results never arrived", expect_q.size());
         errors++;
         expect_q.delete();
      end
      if (errors == err_start) begin
         $display("test %0d %s: pass", num, name);
      end else begin
         $display("test %0d %s: fail with %0d errors", num, name, errors - err_start);
         tests_failed++;
      end
   endtask

   //------------------------------------------------------------
   // Test sequence
   //------------------------------------------------------------
   initial begin
      int   err_start;
      logic finished;
      rst_b          = 1'b0;
      bist_start     = 1'b0;
      func_wr_en     = 1'b0;
      func_wr_addr   = '0;
      func_wr_data   = '0;
      func_search_en = 1'b0;
      func_key       = '0;
      fault_on       = 1'b0;
      fault_entry    = 0;
      fault_bit      = 0;
      errors         = 0;
      tests_failed   = 0;
      repeat (RESET_CYCLES) @(negedge bist_clk);
      rst_b = 1'b1;
      @(negedge bist_clk);

      err_start = errors;
      if (bist_busy !== 1'b0 || bist_done !== 1'b0 || bist_fail !== 1'b0 ||
          match_valid !== 1'b0 || fail_count !== '0) begin
         $display("CHECK FAILED at %0t ns: after reset busy=%b done=%b fail=%b valid=%b count=%0d",
                  $time, bist_busy, bist_done, bist_fail, match_valid, fail_count);
         errors++;
      end
      finish_test(1, "reset state", err_start);

      err_start = errors;
      run_bist(1'b0, finished);
      check_bist_result(finished, ref_fail_count(1'b0, 0, 0));
      finish_test(2, "fault-free BIST", err_start);

      err_start   = errors;
      fault_entry = rand_bits(`CAM_ADDR_W);
      fault_bit   = rand_bits($clog2(`CAM_WIDTH));
      fault_on    = 1'b1;
      $display("stuck-at-1 injected at entry %0d bit %0d", fault_entry, fault_bit);
      run_bist(1'b0, finished);
      check_bist_result(finished, ref_fail_count(1'b1, fault_entry, fault_bit));
      finish_test(3, "stuck-at-1 BIST", err_start);

      err_start = errors;
      fault_on  = 1'b0;
      run_bist(1'b0, finished);
      check_bist_result(finished, ref_fail_count(1'b0, 0, 0));
      finish_test(4, "repeat BIST", err_start);

      err_start = errors;
      mission_test();
      finish_test(5, "mission mode", err_start);

      err_start = errors;
      run_bist(1'b1, finished);
      check_bist_result(finished, 0);
      // Second pass leaves the inverted background in every entry
      for (int e = 0; e < `CAM_ENTRIES; e++) begin
         model_mem[e] = '1;
      end
      search_and_drain('1);
      repeat (2) @(negedge bist_clk);
      finish_test(6, "busy isolation", err_start);

      $display("tests run 6, tests failed %0d, check errors %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the test sequence did not finish",
               WATCHDOG_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+.
cam_types_pkg.sv
bist_pkg.sv
bist_sequencer.sv
cam_bist_inhandler.sv
cam_array.sv
match_analyzer.sv
cam_bist_top.sv
tb_cam_bist.sv

// ==== Bender.yml ====
package:
  name: cam_bist

export_include_dirs:
  - .

sources:
  # RTL in compile order
  - include_dirs:
      - .
    files:
      - cam_types_pkg.sv
      - bist_pkg.sv
      - bist_sequencer.sv
      - cam_bist_inhandler.sv
      - cam_array.sv
      - match_analyzer.sv
      - cam_bist_top.sv
  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_cam_bist.sv
